//--- Bender.yml
package:
  name: cpu_datapath

sources:
  - rtl/lc3b_types.sv
  - rtl/lc3b_control_pkg.sv
  - rtl/stage_bus.sv
  - rtl/instruction_fetch.sv
  - rtl/instruction_decode.sv
  - rtl/execution_module.sv
  - rtl/writeback_module.sv
  - rtl/cpu_datapath.sv
  - target: test
    files:
      - testbench/cpu_datapath_assertions.sv
      - testbench/cpu_datapath_tb.sv

//--- all.f
rtl/lc3b_types.sv
rtl/lc3b_control_pkg.sv
rtl/stage_bus.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/execution_module.sv
rtl/writeback_module.sv
rtl/cpu_datapath.sv
testbench/cpu_datapath_assertions.sv
testbench/cpu_datapath_tb.sv

//--- rtl/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	output lc3b_word mem_addr1,
	input lc3b_word mem_rdata1,
	output lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	input lc3b_word mem_rdata2,
	output lc3b_word mem_wdata2
);

	// fetch to decode.
	lc3b_word if_ir;
	lc3b_word if_pc;
	logic if_valid;

	// register write port back into decode.
	logic reg_load;
	lc3b_reg reg_dest;
	lc3b_word reg_data;

	// redirect and flush from writeback.
	logic branch_taken;
	lc3b_word branch_target;

	// ==================================================================
	// stages
	// ==================================================================

	stage_bus id_ex ();
	stage_bus ex_mem ();

	instruction_fetch if_stage (.*);

	instruction_decode id_stage (.*);

	execution_module ex_stage (.*);

	writeback_module wb_stage (.*); // memory and writeback.

endmodule : cpu_datapath

//--- rtl/execution_module.sv
`timescale 1ns/1ps

module execution_module
	import lc3b_types::*, lc3b_control_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic branch_taken,
	stage_bus.sink id_ex,
	stage_bus.source ex_mem
);

	lc3b_word imm5;
	lc3b_word offset6;
	lc3b_word offset9x2;
	lc3b_word alu_b;
	lc3b_word alu_out;
	lc3b_word addr_sum;

	assign imm5 = {{11{id_ex.ir[4]}}, id_ex.ir[4:0]};
	assign offset6 = {{10{id_ex.ir[5]}}, id_ex.ir[5:0]};
	assign offset9x2 = {{6{id_ex.ir[8]}}, id_ex.ir[8:0], 1'b0};

	// ==================================================================
	// alu
	// ==================================================================

	assign alu_b = id_ex.cw.use_imm ? imm5 : id_ex.b;

	always_comb begin
		case (id_ex.cw.alu_op)
			alu_add: alu_out = id_ex.a + alu_b;
			alu_and: alu_out = id_ex.a & alu_b;
			alu_not: alu_out = ~id_ex.a;
			default: alu_out = alu_b; // alu_pass.
		endcase
	end

	// memory address for ldr/str and branch target otherwise.
	// pc already holds the next instruction address.
	assign addr_sum = id_ex.cw.use_offset6 ? id_ex.a + offset6 : id_ex.pc + offset9x2;

	// execute/memory latch.
	always_ff @(posedge clk) begin
		if (reset || branch_taken) begin
			ex_mem.valid <= 1'b0;
			ex_mem.ir <= nop_word;
			ex_mem.cw <= '0;
		end else begin
			ex_mem.valid <= id_ex.valid;
			ex_mem.ir <= id_ex.ir;
			ex_mem.cw <= id_ex.cw;
		end
		ex_mem.pc <= id_ex.pc;
		ex_mem.a <= addr_sum;
		ex_mem.b <= id_ex.b; // store data.
		ex_mem.result <= alu_out;
	end

endmodule : execution_module

//--- rtl/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode
	import lc3b_types::*, lc3b_control_pkg::*;
(
	input logic clk,
	input logic reset,
	input lc3b_word if_ir,
	input lc3b_word if_pc,
	input logic if_valid,
	input logic reg_load,
	input lc3b_reg reg_dest,
	input lc3b_word reg_data,
	input logic branch_taken,
	stage_bus.source id_ex
);

	lc3b_word regs [8];
	lc3b_opcode opcode;
	lc3b_control cw;
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_word sr1_data;
	lc3b_word sr2_data;

	assign opcode = lc3b_opcode'(if_ir[15:12]);

	// ==================================================================
	// control word decoder
	// ==================================================================

	always_comb begin
		cw = '0;
		case (opcode)
			op_add: begin
				cw.alu_op = alu_add;
				cw.use_imm = if_ir[5];
				cw.reg_load = 1'b1;
				cw.set_cc = 1'b1;
			end
			op_and: begin
				cw.alu_op = alu_and;
				cw.use_imm = if_ir[5];
				cw.reg_load = 1'b1;
				cw.set_cc = 1'b1;
			end
			op_not: begin
				cw.alu_op = alu_not;
				cw.reg_load = 1'b1;
				cw.set_cc = 1'b1;
			end
			op_ldr: begin
				cw.alu_op = alu_pass;
				cw.use_offset6 = 1'b1;
				cw.mem_read = 1'b1;
				cw.reg_load = 1'b1;
				cw.reg_mux = reg_from_mdr;
				cw.set_cc = 1'b1;
			end
			op_str: begin
				cw.alu_op = alu_pass;
				cw.use_offset6 = 1'b1;
				cw.mem_write = 1'b1;
			end
			op_br: begin
				cw.alu_op = alu_pass;
				cw.is_branch = 1'b1;
			end
			default: cw = '0; // outside the subset, dropped.
		endcase
	end

	// ==================================================================
	// register file
	// ==================================================================

	// str reads its source register through the second port.
	assign sr1 = if_ir[8:6];
	assign sr2 = (opcode == op_str) ? if_ir[11:9] : if_ir[2:0];

	// write-through, so a write in this cycle is seen by the reader.
	assign sr1_data = (reg_load && reg_dest == sr1) ? reg_data : regs[sr1];
	assign sr2_data = (reg_load && reg_dest == sr2) ? reg_data : regs[sr2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end else if (reg_load) begin
			regs[reg_dest] <= reg_data;
		end
	end

	// decode/execute latch.
	always_ff @(posedge clk) begin
		if (reset || branch_taken) begin
			id_ex.valid <= 1'b0;
			id_ex.ir <= nop_word;
			id_ex.cw <= '0;
		end else begin
			id_ex.valid <= if_valid;
			id_ex.ir <= if_ir;
			id_ex.cw <= if_valid ? cw : lc3b_control'('0);
		end
		id_ex.pc <= if_pc;
		id_ex.a <= sr1_data;
		id_ex.b <= sr2_data;
		id_ex.result <= '0; // produced by execute.
	end

endmodule : instruction_decode

//--- rtl/instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic branch_taken,
	input lc3b_word branch_target,
	input lc3b_word mem_rdata1,
	output lc3b_word mem_addr1,
	output lc3b_word if_ir,
	output lc3b_word if_pc,
	output logic if_valid
);

	lc3b_word pc;
	lc3b_word pc_next;

	assign pc_next = pc + pc_step;
	assign mem_addr1 = pc;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= reset_pc;
		else if (branch_taken)
			pc <= branch_target; // redirect from writeback.
		else
			pc <= pc_next;
	end

	// ==================================================================
	// fetch/decode latch
	// ==================================================================

	always_ff @(posedge clk) begin
		if (reset || branch_taken) begin
			if_valid <= 1'b0;
			if_ir <= nop_word; // bubble.
		end else begin
			if_valid <= 1'b1;
			if_ir <= mem_rdata1;
		end
		if_pc <= pc_next;
	end

endmodule : instruction_fetch

//--- rtl/lc3b_control_pkg.sv
package lc3b_control_pkg;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} alu_op_t;

	// register write source.
	typedef enum logic {
		reg_from_alu,
		reg_from_mdr
	} regmux_t;

	// ==================================================================
	// control word, built in decode and carried to writeback
	// ==================================================================

	typedef struct packed {
		alu_op_t alu_op;
		logic use_imm; // imm5 replaces the second operand.
		logic use_offset6; // base + offset6, otherwise pc + offset9.
		logic mem_read;
		logic mem_write;
		logic reg_load;
		regmux_t reg_mux;
		logic set_cc;
		logic is_branch;
	} lc3b_control;

	// an all zero word loads nothing, stores nothing and never branches.

endpackage : lc3b_control_pkg

//--- rtl/lc3b_types.sv
package lc3b_types;

	// ==================================================================
	// word and field types
	// ==================================================================

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp; // n, z, p from msb down.

	// only the opcodes this core implements.
	typedef enum logic [3:0] {
		op_br = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001,
		op_ldr = 4'b0110,
		op_str = 4'b0111
	} lc3b_opcode;

	// ==================================================================
	// pipeline constants
	// ==================================================================

	// br with nzp all clear is never taken.
	localparam lc3b_word nop_word = 16'h0000;

	localparam lc3b_word pc_step = 16'd2; // two bytes per instruction.
	localparam lc3b_word reset_pc = 16'h0000;

	// condition code encodings.
	localparam lc3b_nzp cc_n = 3'b100;
	localparam lc3b_nzp cc_z = 3'b010;
	localparam lc3b_nzp cc_p = 3'b001;

endpackage : lc3b_types

//--- rtl/stage_bus.sv
`timescale 1ns/1ps

// one instruction in flight between two pipeline stages.
interface stage_bus
	import lc3b_types::*, lc3b_control_pkg::*;
();

	logic valid;
	lc3b_word ir;
	lc3b_word pc; // already points past the instruction.
	lc3b_control cw;
	lc3b_word a; // first operand, or effective address after execute.
	lc3b_word b; // second operand, or store data.
	lc3b_word result;

	modport source (
		output valid,
		output ir,
		output pc,
		output cw,
		output a,
		output b,
		output result
	);

	modport sink (
		input valid,
		input ir,
		input pc,
		input cw,
		input a,
		input b,
		input result
	);

endinterface : stage_bus

//--- rtl/writeback_module.sv
`timescale 1ns/1ps

module writeback_module
	import lc3b_types::*, lc3b_control_pkg::*;
(
	input logic clk,
	input logic reset,
	stage_bus.sink ex_mem,
	input lc3b_word mem_rdata2,
	output lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_word mem_wdata2,
	output logic reg_load,
	output lc3b_reg reg_dest,
	output lc3b_word reg_data,
	output logic branch_taken,
	output lc3b_word branch_target
);

	logic wb_valid;
	lc3b_control wb_cw;
	lc3b_word wb_ir;
	lc3b_word wb_alu;
	lc3b_word wb_mdr;
	lc3b_word wb_target;
	lc3b_nzp cc;
	lc3b_nzp new_cc;

	// ==================================================================
	// memory stage
	// ==================================================================

	assign mem_addr2 = ex_mem.a;
	assign mem_wdata2 = ex_mem.b;
	assign mem_read2 = ex_mem.cw.mem_read;
	assign mem_write2 = ex_mem.cw.mem_write;

	// memory/writeback latch with the mdr taken straight off the data port.
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_cw <= '0;
		end else begin
			wb_valid <= ex_mem.valid;
			wb_cw <= ex_mem.cw;
		end
		wb_ir <= ex_mem.ir;
		wb_alu <= ex_mem.result;
		wb_mdr <= mem_rdata2;
		wb_target <= ex_mem.a;
	end

	// ==================================================================
	// writeback stage
	// ==================================================================

	assign reg_dest = wb_ir[11:9];
	assign reg_data = (wb_cw.reg_mux == reg_from_mdr) ? wb_mdr : wb_alu;
	assign reg_load = wb_valid && wb_cw.reg_load;

	always_comb begin
		if (reg_data[15])
			new_cc = cc_n;
		else if (reg_data == '0)
			new_cc = cc_z;
		else
			new_cc = cc_p;
	end

	always_ff @(posedge clk) begin
		if (reset)
			cc <= cc_z;
		else if (wb_valid && wb_cw.set_cc)
			cc <= new_cc;
	end

	// compares against cc before this cycle's update.
	// the instruction now in memory still completes.
	assign branch_taken = wb_valid && wb_cw.is_branch && ((wb_ir[11:9] & cc) != 3'b000);
	assign branch_target = wb_target;

endmodule : writeback_module

//--- testbench/cpu_datapath_assertions.sv
`timescale 1ns/1ps

module cpu_datapath_assertions (
	input logic clk,
	input logic reset,
	input logic mem_read2,
	input logic mem_write2,
	input logic reg_load,
	input logic branch_taken
);

	// ==================================================================
	// data port and flush strobes
	// ==================================================================

	read_write_exclusive: assert property (
		@(posedge clk) disable iff (reset) !(mem_read2 && mem_write2)
	) else $error("data port read and write strobes high together");

	branch_one_cycle: assert property (
		@(posedge clk) disable iff (reset) $rose(branch_taken) |=> !branch_taken
	) else $error("branch_taken held for more than one cycle");

	// every strobe comes out of reset low.
	quiet_after_reset: assert property (
		@(posedge clk) reset |=> !(mem_read2 || mem_write2 || reg_load || branch_taken)
	) else $error("strobe high in the cycle after reset");

endmodule : cpu_datapath_assertions

bind cpu_datapath cpu_datapath_assertions assertions0 (
	.clk(clk),
	.reset(reset),
	.mem_read2(mem_read2),
	.mem_write2(mem_write2),
	.reg_load(reg_load),
	.branch_taken(branch_taken)
);

//--- testbench/cpu_datapath_tb.sv
`timescale 1ns/1ps

module cpu_datapath_tb
	import lc3b_types::*;
();

	logic clk;
	logic reset;
	lc3b_word mem_addr1;
	lc3b_word mem_rdata1;
	lc3b_word mem_addr2;
	logic mem_read2;
	logic mem_write2;
	lc3b_word mem_rdata2;
	lc3b_word mem_wdata2;

	lc3b_word rom [256];
	lc3b_word ram [256];
	lc3b_word prog [$];
	lc3b_word store_addr [$];
	lc3b_word store_data [$];
	lc3b_word exp_addr [$];
	lc3b_word exp_data [$];
	integer seed = 32'h55fe2312;

	cpu_datapath dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================================
	// memory models
	// ==================================================================

	assign mem_rdata1 = (mem_addr1 < 16'd512) ? rom[mem_addr1[8:1]] : nop_word;

	// no wait states.
	assign mem_rdata2 = mem_read2 ? ram[mem_addr2[7:0]] : 16'hxxxx; // unknown without the strobe.

	always @(posedge clk) begin
		if (mem_write2) begin
			ram[mem_addr2[7:0]] = mem_wdata2;
			store_addr.push_back(mem_addr2);
			store_data.push_back(mem_wdata2);
		end
	end

	// add is 0001, and is 0101.
	function automatic lc3b_word alu_reg(input logic [3:0] op, input lc3b_reg dr,
			input lc3b_reg sr1, input lc3b_reg sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic lc3b_word alu_imm(input logic [3:0] op, input lc3b_reg dr,
			input lc3b_reg sr1, input int imm);
		return {op, dr, sr1, 1'b1, 5'(imm)};
	endfunction

	function automatic lc3b_word not_of(input lc3b_reg dr, input lc3b_reg sr);
		return {4'b1001, dr, sr, 6'b111111};
	endfunction

	// ldr is 0110, str is 0111.
	function automatic lc3b_word mem_op(input logic [3:0] op, input lc3b_reg r,
			input lc3b_reg base, input int offset);
		return {op, r, base, 6'(offset)};
	endfunction

	function automatic lc3b_word branch(input lc3b_nzp nzp, input int offset);
		return {4'b0000, nzp, 9'(offset)};
	endfunction

	task automatic emit(input lc3b_word w, input int nops = 0);
		prog.push_back(w);
		repeat (nops) prog.push_back(nop_word);
	endtask

	task automatic expect_store(input lc3b_word addr, input lc3b_word data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_equal(input lc3b_word actual, input lc3b_word expected,
			input string what);
		if (actual !== expected)
			stop_with_failure($sformatf("CHECK FAILED at %0d ns: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	// memories are loaded while reset holds the core for two edges.
	task automatic start_program();
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		store_addr.delete();
		store_data.delete();
		for (int i = 0; i < 256; i++) begin
			rom[i] = (i < prog.size()) ? prog[i] : nop_word;
			ram[i] = {~i[7:0], i[7:0]};
		end
		reset <= 1'b0;
	endtask

	task automatic wait_and_compare_stores(input string name);
		int cycles;
		cycles = 0;
		while (store_addr.size() < exp_addr.size()) begin
			@(negedge clk);
			cycles++;
			if (cycles > 400)
				stop_with_failure($sformatf("timeout: %s test produced %0d of %0d stores",
					name, store_addr.size(), exp_addr.size()));
		end
		repeat (6) @(negedge clk); // a stray store would land here.
		check_equal(16'(store_addr.size()), 16'(exp_addr.size()), {name, " store count"});
		foreach (exp_addr[i]) begin
			check_equal(store_addr[i], exp_addr[i], $sformatf("%s store %0d address", name, i));
			check_equal(store_data[i], exp_data[i], $sformatf("%s store %0d data", name, i));
		end
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	// ==================================================================
	// directed tests
	// ==================================================================

	task automatic test_reset_state();
		int n;
		repeat (4) emit(nop_word);
		emit(mem_op(4'b0111, 3'd0, 3'd0, 6));
		expect_store(16'd6, 16'd0);
		start_program();
		@(negedge clk);
		check_equal(mem_addr1, 16'h0000, "fetch address after reset");
		n = 0;
		while (!mem_write2) begin
			check_equal(16'(mem_read2), 16'd0, "read strobe before the first store");
			n++;
			if (n > 20)
				stop_with_failure("no data write strobe appeared after reset");
			@(negedge clk);
		end
		check_equal(16'(n), 16'd7, "cycles to first store"); // fifth word plus three stages.
		wait_and_compare_stores("reset");
	endtask

	task automatic test_alu();
		lc3b_word r1;
		lc3b_word r2;
		lc3b_word base;
		r1 = 16'd7;
		r2 = 16'hfffd; // -3.
		base = 16'd12;
		emit(alu_imm(4'b0001, 3'd1, 3'd0, 7), 2);
		emit(alu_imm(4'b0001, 3'd2, 3'd0, -3), 2);
		emit(alu_reg(4'b0001, 3'd3, 3'd1, 3'd2), 2);
		emit(alu_imm(4'b0101, 3'd4, 3'd1, 5), 2);
		emit(alu_reg(4'b0101, 3'd5, 3'd2, 3'd3), 2);
		emit(not_of(3'd6, 3'd3), 2);
		emit(alu_imm(4'b0001, 3'd7, 3'd0, 12), 2);
		emit(alu_imm(4'b0101, 3'd0, 3'd2, -8), 2); // r0 no longer needed as zero.
		emit(mem_op(4'b0111, 3'd3, 3'd7, 4));
		emit(mem_op(4'b0111, 3'd4, 3'd7, 6));
		emit(mem_op(4'b0111, 3'd5, 3'd7, 8));
		emit(mem_op(4'b0111, 3'd6, 3'd7, 10));
		emit(mem_op(4'b0111, 3'd0, 3'd7, -2));
		expect_store(base + 16'd4, r1 + r2);
		expect_store(base + 16'd6, r1 & 16'd5);
		expect_store(base + 16'd8, r2 & (r1 + r2));
		expect_store(base + 16'd10, ~(r1 + r2));
		expect_store(base - 16'd2, r2 & 16'hfff8);
		start_program();
		wait_and_compare_stores("alu");
	endtask

	task automatic test_load_store();
		emit(alu_imm(4'b0001, 3'd1, 3'd0, 10), 2);
		emit(mem_op(4'b0110, 3'd2, 3'd0, 20));
		emit(mem_op(4'b0110, 3'd3, 3'd0, -12));
		emit(mem_op(4'b0110, 3'd4, 3'd1, -4), 2); // reads the fill word at 6.
		emit(mem_op(4'b0111, 3'd2, 3'd0, 30));
		emit(mem_op(4'b0111, 3'd3, 3'd1, 16));
		emit(mem_op(4'b0111, 3'd4, 3'd1, 15));
		expect_store(16'd30, 16'hbeef);
		expect_store(16'd26, 16'h1234);
		expect_store(16'd25, {~8'd6, 8'd6});
		start_program();
		ram[20] = 16'hbeef;
		ram[8'hf4] = 16'h1234; // 0 minus 12 wraps to 16'hfff4.
		wait_and_compare_stores("load/store");
	endtask

	// the word right behind a branch always completes and the next three are flushed.
	task automatic test_branch(input lc3b_nzp nzp);
		logic taken;
		taken = (nzp & 3'b001) != 3'b000; // r1 = 5 leaves the codes at p.
		emit(alu_imm(4'b0001, 3'd1, 3'd0, 5), 2);
		emit(branch(nzp, 4)); // word 3 jumps to word 8.
		emit(nop_word);
		for (int i = 1; i <= 3; i++) begin
			emit(mem_op(4'b0111, 3'd1, 3'd0, 2 * i));
			if (!taken)
				expect_store(16'(2 * i), 16'd5);
		end
		emit(mem_op(4'b0111, 3'd1, 3'd0, 8));
		expect_store(16'd8, 16'd5);
		start_program();
		wait_and_compare_stores($sformatf("branch nzp %b", nzp));
	endtask

	task automatic test_random_sums();
		lc3b_word a;
		lc3b_word b;
		emit(alu_imm(4'b0001, 3'd7, 3'd0, 15), 2);
		emit(alu_imm(4'b0001, 3'd7, 3'd7, 15), 2); // sums go from 30 up.
		for (int i = 0; i < 20; i++) begin
			emit(mem_op(4'b0110, 3'd1, 3'd0, i));
			emit(mem_op(4'b0110, 3'd2, 3'd0, -1 - i), 2);
			emit(alu_reg(4'b0001, 3'd3, 3'd1, 3'd2), 2);
			emit(mem_op(4'b0111, 3'd3, 3'd7, i));
		end
		start_program();
		for (int i = 0; i < 20; i++) begin
			a = 16'($random(seed));
			b = 16'($random(seed));
			ram[i] = a;
			ram[255 - i] = b;
			expect_store(16'd30 + 16'(i), a + b);
		end
		wait_and_compare_stores("random sums");
	endtask

	initial begin
		reset = 1'b1;
		test_reset_state();
		test_alu();
		test_load_store();
		test_branch(3'b001);
		test_branch(3'b110);
		test_branch(3'b011);
		test_random_sums();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule : cpu_datapath_tb
